//--- rtl/aguPkg.sv
package aguPkg;

    // address and page number widths for Sv32 with a 32-bit physical space
    parameter int addrWidth = 32;
    parameter int vpnWidth = 20;
    parameter int ppnWidth = 20;
    parameter int tagWidth = 7;

    // access kind; loads use all five, stores only byte, half and word
    typedef enum logic [2:0] {
        opB  = 3'd0,
        opH  = 3'd1,
        opW  = 3'd2,
        opBu = 3'd4,
        opHu = 3'd5
    } aguOpcode_t;

    typedef enum logic [1:0] {
        excNone        = 2'd0,
        excMisalign    = 2'd1,
        excPageFault   = 2'd2,
        excAccessFault = 2'd3
    } aguExcept_t;

    // legal physical windows are 0x0xxxxxxx and 0x8xxxxxxx
    function automatic logic isLegalAddr(input logic [addrWidth-1:0] addr);
        logic [3:0] top;
        top = addr[addrWidth-1 -: 4];
        return (top == 4'h0) || (top == 4'h8);
    endfunction

endpackage

//--- rtl/aguDecode.sv
`timescale 1ns/1ps

module aguDecode import aguPkg::*; #(
    parameter int isLoadUnit = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       uopValid,
    input  aguOpcode_t opcode,
    output logic [1:0] size,
    output logic       signExtend,
    output logic [1:0] alignMask
);

    logic legalOp;

    always_comb begin
        size = 2'd2;
        signExtend = 1'b0;
        alignMask = 2'b11;
        legalOp = 1'b1;
        case (opcode)
            opB: begin
                size = 2'd0;
                signExtend = (isLoadUnit != 0);
                alignMask = 2'b00;
            end
            opH: begin
                size = 2'd1;
                signExtend = (isLoadUnit != 0);
                alignMask = 2'b01;
            end
            opW: ;
            // unsigned variants only exist for loads
            opBu: begin
                size = 2'd0;
                alignMask = 2'b00;
                legalOp = (isLoadUnit != 0);
            end
            opHu: begin
                size = 2'd1;
                alignMask = 2'b01;
                legalOp = (isLoadUnit != 0);
            end
            default: legalOp = 1'b0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) uopValid |-> legalOp)
        else $error("opcode %0d illegal for this unit", opcode);

endmodule

//--- rtl/aguTransCache.sv
`timescale 1ns/1ps

module aguTransCache import aguPkg::*; #(
    parameter int tlbEntries = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [vpnWidth-1:0] lookupVpn,
    output logic                hit,
    output logic [ppnWidth-1:0] ppn,
    output logic [2:0]          rwx,
    output logic                user,
    input  logic                refillValid,
    input  logic [vpnWidth-1:0] refillVpn,
    input  logic [ppnWidth-1:0] refillPpn,
    input  logic [2:0]          refillRwx,
    input  logic                refillUser
);

    localparam int idxWidth = $clog2(tlbEntries);
    localparam int entryTagWidth = vpnWidth - idxWidth;

    logic [tlbEntries-1:0]    entryValid;
    logic [entryTagWidth-1:0] entryTag [tlbEntries];
    logic [ppnWidth-1:0]      entryPpn [tlbEntries];
    logic [2:0]               entryRwx [tlbEntries];
    logic                     entryUser [tlbEntries];

    logic [idxWidth-1:0] lookupIdx;
    logic [idxWidth-1:0] refillIdx;

    assign lookupIdx = lookupVpn[idxWidth-1:0];
    assign refillIdx = refillVpn[idxWidth-1:0];

    // lookup answers in the same cycle
    assign hit = entryValid[lookupIdx]
        && (entryTag[lookupIdx] == lookupVpn[vpnWidth-1:idxWidth]);
    assign ppn = entryPpn[lookupIdx];
    assign rwx = entryRwx[lookupIdx];
    assign user = entryUser[lookupIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (refillValid) begin
            entryValid[refillIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refillValid) begin
            entryTag[refillIdx] <= refillVpn[vpnWidth-1:idxWidth];
            entryPpn[refillIdx] <= refillPpn;
            entryRwx[refillIdx] <= refillRwx;
            entryUser[refillIdx] <= refillUser;
        end
    end

    assert property (@(posedge clk) (tlbEntries & (tlbEntries - 1)) == 0)
        else $error("tlbEntries must be a power of two");

endmodule

//--- rtl/aguTranslate.sv
`timescale 1ns/1ps

module aguTranslate import aguPkg::*; #(
    parameter int isLoadUnit = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 uopValid,
    input  aguOpcode_t           opcode,
    input  logic [addrWidth-1:0] base,
    input  logic [11:0]          imm,
    input  logic [tagWidth-1:0]  tag,
    input  logic                 stall,
    input  logic                 sv32En,
    input  logic                 privUser,
    input  logic                 sum,
    input  logic [ppnWidth-1:0]  rootPpn,
    input  logic [1:0]           size,
    input  logic                 signExtend,
    input  logic [1:0]           alignMask,
    output logic                 busy,
    output logic                 pwValid,
    output logic [addrWidth-1:0] pwVaddr,
    output logic [ppnWidth-1:0]  pwRoot,
    input  logic                 pwResValid,
    input  logic [ppnWidth-1:0]  pwPpn,
    input  logic                 pwFault,
    input  logic [2:0]           pwRwx,
    input  logic                 pwUser,
    output logic [vpnWidth-1:0]  lookupVpn,
    input  logic                 hit,
    input  logic [ppnWidth-1:0]  ppn,
    input  logic [2:0]           rwx,
    input  logic                 user,
    output logic                 refillValid,
    output logic [vpnWidth-1:0]  refillVpn,
    output logic [ppnWidth-1:0]  refillPpn,
    output logic [2:0]           refillRwx,
    output logic                 refillUser,
    output logic                 doneValid,
    output logic [addrWidth-1:0] doneAddr,
    output logic [tagWidth-1:0]  doneTag,
    output logic [1:0]           doneSize,
    output logic                 doneSignExtend,
    output aguExcept_t           doneExcept,
    output logic [addrWidth-1:0] doneVaddr
);

    typedef enum logic [1:0] {stIdle, stReq, stWait} walkState_t;

    walkState_t state;
    logic accept, misaligned, needWalk, walkDone;
    logic [addrWidth-1:0] vaddr, paddr, walkAddr;
    aguExcept_t acceptExcept, walkExcept;

    // micro-op parked while the walker works
    logic [addrWidth-1:0] heldVaddr;
    logic [tagWidth-1:0]  heldTag;
    logic [1:0]           heldSize;
    logic                 heldSignExtend;

    // rwx is ordered r, w, x from bit 2 down
    function automatic logic permFault(input logic [2:0] pteRwx, input logic pteUser);
        logic noAccess;
        noAccess = (isLoadUnit != 0) ? !pteRwx[2] : !pteRwx[1];
        return noAccess || (privUser && !pteUser) || (!privUser && pteUser && !sum);
    endfunction

    assign accept = uopValid && !stall && !busy;
    assign vaddr = base + {{(addrWidth-12){imm[11]}}, imm};
    assign lookupVpn = vaddr[addrWidth-1 -: vpnWidth];
    assign misaligned = |(vaddr[1:0] & alignMask);
    assign needWalk = sv32En && !misaligned && !hit;
    // a misaligned access keeps its virtual address, the cache entry may be stale
    assign paddr = (sv32En && !misaligned) ? {ppn, vaddr[11:0]} : vaddr;
    assign walkDone = (state != stIdle) && pwResValid;
    assign walkAddr = {pwPpn, heldVaddr[11:0]};

    always_comb begin
        if (misaligned)
            acceptExcept = excMisalign;
        else if (sv32En && permFault(rwx, user))
            acceptExcept = excPageFault;
        else if (!isLegalAddr(paddr))
            acceptExcept = excAccessFault;
        else
            acceptExcept = excNone;
    end

    always_comb begin
        if (pwFault || permFault(pwRwx, pwUser))
            walkExcept = excPageFault;
        else if (!isLegalAddr(walkAddr))
            walkExcept = excAccessFault;
        else
            walkExcept = excNone;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: if (accept && needWalk) state <= stReq;
                stReq: state <= walkDone ? stIdle : stWait;
                stWait: if (pwResValid) state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldVaddr <= vaddr;
            heldTag <= tag;
            heldSize <= size;
            heldSignExtend <= signExtend;
        end
    end

    assign busy = (state != stIdle);
    assign pwValid = (state == stReq);
    assign pwVaddr = heldVaddr;
    assign pwRoot = rootPpn;

    // faulting walks are not cached
    assign refillValid = walkDone && !pwFault;
    assign refillVpn = heldVaddr[addrWidth-1 -: vpnWidth];
    assign refillPpn = pwPpn;
    assign refillRwx = pwRwx;
    assign refillUser = pwUser;

    assign doneValid = (accept && !needWalk) || walkDone;
    assign doneAddr = walkDone ? walkAddr : paddr;
    assign doneTag = walkDone ? heldTag : tag;
    assign doneSize = walkDone ? heldSize : size;
    assign doneSignExtend = walkDone ? heldSignExtend : signExtend;
    assign doneExcept = walkDone ? walkExcept : acceptExcept;
    assign doneVaddr = walkDone ? heldVaddr : vaddr;

    assert property (@(posedge clk) disable iff (rst) busy |-> !uopValid)
        else $error("micro-op offered while busy, opcode %0d", opcode);

endmodule

//--- rtl/aguResult.sv
`timescale 1ns/1ps

module aguResult import aguPkg::*; #(
    parameter int isLoadUnit = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 doneValid,
    input  logic [addrWidth-1:0] doneAddr,
    input  logic [tagWidth-1:0]  doneTag,
    input  logic [1:0]           doneSize,
    input  logic                 doneSignExtend,
    input  aguExcept_t           doneExcept,
    input  logic [addrWidth-1:0] doneVaddr,
    output logic                 resValid,
    output logic [addrWidth-1:0] resAddr,
    output logic [tagWidth-1:0]  resTag,
    output logic [1:0]           resSize,
    output logic                 resSignExtend,
    output logic                 resIsLoad,
    output logic [3:0]           resWmask,
    output aguExcept_t           resExcept,
    output logic                 tvalValid,
    output logic [addrWidth-1:0] tval
);

    logic [3:0] sizeMask;
    logic [3:0] wmask;

    always_comb begin
        case (doneSize)
            2'd0: sizeMask = 4'b0001;
            2'd1: sizeMask = 4'b0011;
            default: sizeMask = 4'b1111;
        endcase
    end

    // loads write nothing, a misaligned store never reaches memory
    assign wmask = ((isLoadUnit != 0) || doneExcept == excMisalign)
        ? 4'b0000 : sizeMask << doneAddr[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            tvalValid <= 1'b0;
        end else begin
            resValid <= doneValid;
            tvalValid <= doneValid && (doneExcept != excNone);
        end
    end

    always_ff @(posedge clk) begin
        if (doneValid) begin
            resAddr <= doneAddr;
            resTag <= doneTag;
            resSize <= doneSize;
            resSignExtend <= doneSignExtend;
            resWmask <= wmask;
            resExcept <= doneExcept;
            tval <= doneVaddr;
        end
    end

    assign resIsLoad = (isLoadUnit != 0);

    assert property (@(posedge clk) disable iff (rst)
        resValid && resExcept == excMisalign |-> resWmask == 4'b0000)
        else $error("misaligned result with byte mask %b", resWmask);

endmodule

//--- rtl/aguTop.sv
`timescale 1ns/1ps

module aguTop import aguPkg::*; #(
    parameter int isLoadUnit = 1,
    parameter int tlbEntries = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 uopValid,
    input  aguOpcode_t           opcode,
    input  logic [addrWidth-1:0] base,
    input  logic [11:0]          imm,
    input  logic [tagWidth-1:0]  tag,
    input  logic                 stall,
    input  logic                 sv32En,
    input  logic                 privUser,
    input  logic                 sum,
    input  logic [ppnWidth-1:0]  rootPpn,
    output logic                 busy,
    output logic                 pwValid,
    output logic [addrWidth-1:0] pwVaddr,
    output logic [ppnWidth-1:0]  pwRoot,
    input  logic                 pwResValid,
    input  logic [ppnWidth-1:0]  pwPpn,
    input  logic                 pwFault,
    input  logic [2:0]           pwRwx,
    input  logic                 pwUser,
    output logic                 resValid,
    output logic [addrWidth-1:0] resAddr,
    output logic [tagWidth-1:0]  resTag,
    output logic [1:0]           resSize,
    output logic                 resSignExtend,
    output logic                 resIsLoad,
    output logic [3:0]           resWmask,
    output aguExcept_t           resExcept,
    output logic                 tvalValid,
    output logic [addrWidth-1:0] tval
);

    logic [1:0] size;
    logic signExtend;
    logic [1:0] alignMask;

    logic [vpnWidth-1:0] lookupVpn;
    logic hit;
    logic [ppnWidth-1:0] ppn;
    logic [2:0] rwx;
    logic user;

    logic refillValid;
    logic [vpnWidth-1:0] refillVpn;
    logic [ppnWidth-1:0] refillPpn;
    logic [2:0] refillRwx;
    logic refillUser;

    logic doneValid;
    logic [addrWidth-1:0] doneAddr;
    logic [tagWidth-1:0] doneTag;
    logic [1:0] doneSize;
    logic doneSignExtend;
    aguExcept_t doneExcept;
    logic [addrWidth-1:0] doneVaddr;

    aguDecode #(.isLoadUnit(isLoadUnit)) aguDecode_i (
        .clk(clk), .rst(rst), .uopValid(uopValid), .opcode(opcode),
        .size(size), .signExtend(signExtend), .alignMask(alignMask)
    );

    aguTransCache #(.tlbEntries(tlbEntries)) aguTransCache_i (
        .clk(clk), .rst(rst), .lookupVpn(lookupVpn),
        .hit(hit), .ppn(ppn), .rwx(rwx), .user(user),
        .refillValid(refillValid), .refillVpn(refillVpn), .refillPpn(refillPpn),
        .refillRwx(refillRwx), .refillUser(refillUser)
    );

    aguTranslate #(.isLoadUnit(isLoadUnit)) aguTranslate_i (
        .clk(clk), .rst(rst), .uopValid(uopValid), .opcode(opcode),
        .base(base), .imm(imm), .tag(tag), .stall(stall),
        .sv32En(sv32En), .privUser(privUser), .sum(sum), .rootPpn(rootPpn),
        .size(size), .signExtend(signExtend), .alignMask(alignMask),
        .busy(busy), .pwValid(pwValid), .pwVaddr(pwVaddr), .pwRoot(pwRoot),
        .pwResValid(pwResValid), .pwPpn(pwPpn), .pwFault(pwFault),
        .pwRwx(pwRwx), .pwUser(pwUser),
        .lookupVpn(lookupVpn), .hit(hit), .ppn(ppn), .rwx(rwx), .user(user),
        .refillValid(refillValid), .refillVpn(refillVpn), .refillPpn(refillPpn),
        .refillRwx(refillRwx), .refillUser(refillUser),
        .doneValid(doneValid), .doneAddr(doneAddr), .doneTag(doneTag),
        .doneSize(doneSize), .doneSignExtend(doneSignExtend),
        .doneExcept(doneExcept), .doneVaddr(doneVaddr)
    );

    aguResult #(.isLoadUnit(isLoadUnit)) aguResult_i (
        .clk(clk), .rst(rst),
        .doneValid(doneValid), .doneAddr(doneAddr), .doneTag(doneTag),
        .doneSize(doneSize), .doneSignExtend(doneSignExtend),
        .doneExcept(doneExcept), .doneVaddr(doneVaddr),
        .resValid(resValid), .resAddr(resAddr), .resTag(resTag),
        .resSize(resSize), .resSignExtend(resSignExtend), .resIsLoad(resIsLoad),
        .resWmask(resWmask), .resExcept(resExcept),
        .tvalValid(tvalValid), .tval(tval)
    );

endmodule

//--- verification/aguTb.sv
`timescale 1ns/1ps

module aguTb import aguPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int isLoad = 1;
    localparam int tlbSize = 8;
    localparam int idxBits = $clog2(tlbSize);
    localparam int numCycles = 900;
    localparam int drainCycles = 16;
    // request cycle, up to six cycles of walker delay, response and result
    localparam int worstLatency = 9;
    localparam int timeoutCycles = (numCycles + drainCycles) * worstLatency;
    localparam logic [ppnWidth-1:0] ppnKey = 20'h80000;
    localparam logic [ppnWidth-1:0] rootValue = 20'h00123;

    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [tagWidth-1:0]  tag;
        logic [1:0]           size;
        logic                 signExtend;
        logic [3:0]           wmask;
        aguExcept_t           except;
        logic [addrWidth-1:0] vaddr;
    } expected_t;

    logic clk, rst;
    logic uopValid;
    aguOpcode_t opcode;
    logic [addrWidth-1:0] base;
    logic [11:0] imm;
    logic [tagWidth-1:0] tag;
    logic stall, sv32En, privUser, sum;
    logic [ppnWidth-1:0] rootPpn;
    logic busy, pwValid;
    logic [addrWidth-1:0] pwVaddr;
    logic [ppnWidth-1:0] pwRoot;
    logic pwResValid;
    logic [ppnWidth-1:0] pwPpn;
    logic pwFault;
    logic [2:0] pwRwx;
    logic pwUser;
    logic resValid;
    logic [addrWidth-1:0] resAddr;
    logic [tagWidth-1:0] resTag;
    logic [1:0] resSize;
    logic resSignExtend, resIsLoad;
    logic [3:0] resWmask;
    aguExcept_t resExcept;
    logic tvalValid;
    logic [addrWidth-1:0] tval;

    logic [31:0] rngState;
    int errorCount;
    int checkCount;
    expected_t expQueue[$];
    // copy of the translation cache contents, filled from walker answers
    logic [tlbSize-1:0] mirrorValid;
    logic [vpnWidth-1:0] mirrorVpn [tlbSize];

    aguTop #(.isLoadUnit(isLoad), .tlbEntries(tlbSize)) aguTop_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic aguOpcode_t pickOpcode(input logic [31:0] r);
        int sel;
        sel = int'(r % ((isLoad != 0) ? 32'd5 : 32'd3));
        case (sel)
            0: return opB;
            1: return opH;
            3: return opBu;
            4: return opHu;
            default: return opW;
        endcase
    endfunction

    // page table rule used by the walker
    function automatic logic walkFaults(input logic [vpnWidth-1:0] vpn);
        return vpn[3:0] == 4'hF;
    endfunction

    function automatic expected_t expectedFor(input aguOpcode_t op,
            input logic [addrWidth-1:0] b, input logic [11:0] im,
            input logic [tagWidth-1:0] t, input logic pg, input logic pu, input logic sm);
        expected_t e;
        logic [vpnWidth-1:0] vpn;
        logic [3:0] bytes;
        logic misaligned, noPerm, pteUser;
        logic [2:0] pteRwx;
        e.vaddr = b + {{20{im[11]}}, im};
        e.tag = t;
        e.size = (op == opB || op == opBu) ? 2'd0 : (op == opW) ? 2'd2 : 2'd1;
        e.signExtend = (isLoad != 0) && (op == opB || op == opH);
        misaligned = (e.size == 2'd1 && e.vaddr[0])
            || (e.size == 2'd2 && e.vaddr[1:0] != 2'b00);
        vpn = e.vaddr[addrWidth-1 -: vpnWidth];
        pteRwx = vpn[2:0];
        pteUser = vpn[3];
        noPerm = (isLoad != 0) ? !pteRwx[2] : !pteRwx[1];
        e.addr = (pg && !misaligned) ? {vpn ^ ppnKey, e.vaddr[11:0]} : e.vaddr;
        if (misaligned)
            e.except = excMisalign;
        else if (pg && (walkFaults(vpn) || noPerm || (pu && !pteUser) || (!pu && pteUser && !sm)))
            e.except = excPageFault;
        else if (e.addr[31:28] != 4'h0 && e.addr[31:28] != 4'h8)
            e.except = excAccessFault;
        else
            e.except = excNone;
        bytes = (e.size == 2'd0) ? 4'b0001 : (e.size == 2'd1) ? 4'b0011 : 4'b1111;
        e.wmask = (isLoad != 0 || misaligned) ? 4'b0000 : bytes << e.vaddr[1:0];
        return e;
    endfunction

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp)
            reportMismatch($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic checkResult(input expected_t e);
        checkCount++;
        if (resAddr !== e.addr || resTag !== e.tag || resSize !== e.size
                || resSignExtend !== e.signExtend || resWmask !== e.wmask
                || resExcept !== e.except || resIsLoad !== (isLoad != 0))
            reportMismatch($sformatf(
                "result tag %0d addr %h size %0d sext %b mask %b %s, expected %0d %h %0d %b %b %s",
                resTag, resAddr, resSize, resSignExtend, resWmask, resExcept.name(),
                e.tag, e.addr, e.size, e.signExtend, e.wmask, e.except.name()));
    endtask

    task automatic checkTval(input aguExcept_t except, input logic [addrWidth-1:0] vaddr);
        checkCount++;
        if (tvalValid !== (except != excNone))
            reportMismatch($sformatf("tvalValid %b with %s", tvalValid, except.name()));
        else if (tvalValid && tval !== vaddr)
            reportMismatch($sformatf("tval %h, expected %h", tval, vaddr));
    endtask

    task automatic checkWalkReq(input logic [addrWidth-1:0] vaddr);
        checkCount++;
        if (pwVaddr !== vaddr || pwRoot !== rootValue)
            reportMismatch($sformatf("walk request %h root %h, expected %h root %h",
                pwVaddr, pwRoot, vaddr, rootValue));
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("watchdog expired at %0t before the test loop ended", $time);
        $display("tests failed");
        $finish;
    end

    initial begin
        expected_t e, front;
        logic accepted, miss, curRes, nextRes, predBusy, nextBusy, expectRes, expectPw;
        logic sValid, sStall, sSv32, sPriv, sSum;
        aguOpcode_t sOp;
        logic [addrWidth-1:0] sBase, pendVaddr, va;
        logic [11:0] sImm;
        logic [tagWidth-1:0] sTag;
        logic [vpnWidth-1:0] vpn, walkVpn;
        logic [31:0] r, r2;
        logic [3:0] top;
        int walkCount, phase;

        rst = 1'b1;
        uopValid = 1'b0;
        opcode = opW;
        base = '0;
        imm = '0;
        tag = '0;
        stall = 1'b0;
        sv32En = 1'b0;
        privUser = 1'b0;
        sum = 1'b0;
        rootPpn = rootValue;
        pwResValid = 1'b0;
        pwPpn = '0;
        pwFault = 1'b0;
        pwRwx = '0;
        pwUser = 1'b0;
        rngState = 32'd63734;
        errorCount = 0;
        checkCount = 0;
        mirrorValid = '0;
        {sValid, sStall, sSv32, sPriv, sSum} = '0;
        sOp = opW;
        sBase = '0;
        sImm = '0;
        sTag = '0;
        pendVaddr = '0;
        walkVpn = '0;
        {curRes, predBusy, expectRes, expectPw} = '0;
        walkCount = 0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int cyc = 0; cyc < numCycles + drainCycles; cyc++) begin
            @(posedge clk);
            // outputs seen here belong to the cycle that just ended
            checkLevel("busy", busy, predBusy);
            checkLevel("pwValid", pwValid, expectPw);
            if (pwValid && expectPw)
                checkWalkReq(pendVaddr);
            checkLevel("resValid", resValid, expectRes);
            if (resValid && expectRes) begin
                front = expQueue.pop_front();
                checkResult(front);
                checkTval(front.except, front.vaddr);
            end else if (!resValid) begin
                checkLevel("tvalValid", tvalValid, 1'b0);
            end

            accepted = sValid && !sStall && !predBusy;
            miss = 1'b0;
            if (accepted) begin
                e = expectedFor(sOp, sBase, sImm, sTag, sSv32, sPriv, sSum);
                expQueue.push_back(e);
                vpn = e.vaddr[addrWidth-1 -: vpnWidth];
                miss = sSv32 && e.except != excMisalign
                    && !(mirrorValid[vpn[idxBits-1:0]] && mirrorVpn[vpn[idxBits-1:0]] == vpn);
                if (miss)
                    pendVaddr = e.vaddr;
            end
            if (curRes) begin
                vpn = pendVaddr[addrWidth-1 -: vpnWidth];
                if (!walkFaults(vpn)) begin
                    mirrorValid[vpn[idxBits-1:0]] = 1'b1;
                    mirrorVpn[vpn[idxBits-1:0]] = vpn;
                end
            end
            expectRes = (accepted && !miss) || curRes;
            expectPw = accepted && miss;
            nextBusy = (accepted && miss) || (predBusy && !curRes);

            // page walker answers each request after 1 to 6 cycles
            nextRes = 1'b0;
            if (walkCount > 0) begin
                walkCount--;
                nextRes = (walkCount == 0);
            end
            if (pwValid) begin
                walkVpn = pwVaddr[addrWidth-1 -: vpnWidth];
                walkCount = int'(randWord() % 32'd6) + 1;
            end
            pwResValid <= nextRes;
            pwPpn <= walkVpn ^ ppnKey;
            pwRwx <= walkVpn[2:0];
            pwUser <= walkVpn[3];
            pwFault <= walkFaults(walkVpn);
            curRes = nextRes;
            predBusy = nextBusy;

            r = randWord();
            sStall = (cyc < numCycles) && (cyc >= 150) && (r[2:0] == 3'b000);
            sValid = 1'b0;
            if (cyc < numCycles && !nextBusy) begin
                phase = (cyc < 150) ? 0 : (cyc < 300) ? 1 : 2;
                sValid = r[3] | r[4];
                sOp = pickOpcode(randWord());
                r = randWord();
                r2 = randWord();
                if (phase == 2) begin
                    // small page pool so that VPNs repeat and hit
                    case (r[1:0])
                        2'd1: top = 4'h8;
                        2'd3: top = r[6] ? 4'h2 : 4'h8;
                        default: top = 4'h0;
                    endcase
                    va = {top, 8'h3C, 4'h1, r[5:2], r[27:16]};
                end else begin
                    va = r;
                end
                if (phase == 0 || r2[31:30] != 2'b00) begin
                    if (sOp == opW)
                        va[1:0] = 2'b00;
                    else if (sOp == opH || sOp == opHu)
                        va[0] = 1'b0;
                end
                sImm = r2[11:0];
                sBase = va - {{20{sImm[11]}}, sImm};
                sTag = sTag + 1'b1;
                sSv32 = (phase == 2);
                sPriv = r2[12];
                sSum = r2[13];
            end
            uopValid <= sValid;
            opcode <= sOp;
            base <= sBase;
            imm <= sImm;
            tag <= sTag;
            stall <= sStall;
            sv32En <= sSv32;
            privUser <= sPriv;
            sum <= sSum;
        end

        if (expQueue.size() != 0) begin
            errorCount++;
            $display("%0d accepted micro-ops never produced a result", expQueue.size());
        end
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- flist.f
rtl/aguPkg.sv
rtl/aguDecode.sv
rtl/aguTransCache.sv
rtl/aguTranslate.sv
rtl/aguResult.sv
rtl/aguTop.sv
verification/aguTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = aguTb
FILELIST = flist.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
